// File: design/dt_cfg_pkg.sv
package dt_cfg_pkg;

  // Register opcodes on the configuration write port
  typedef enum logic [1:0] {
    OP_CTRL       = 2'd0,  // Bit 0 is the start level
    OP_NUM_TREES  = 2'd1,
    OP_DEPTH      = 2'd2,
    OP_NUM_TUPLES = 2'd3
  } cfg_op_e;

  // Run parameters as held by the register file
  typedef struct packed {
    logic [4:0]  spare;
    logic [2:0]  num_trees;   // 1 to 4
    logic [1:0]  depth;       // 1 to 3
    logic [15:0] num_tuples;
  } dt_params_t;

endpackage

// File: design/dt_inference_top.sv
module dt_inference_top #(
  parameter  int MAX_TREES = 4,
  parameter  int MAX_DEPTH = 3
) (
  input  logic                      aclk,
  input  logic                      aresetn,
  // Configuration writes
  input  logic                      cfg_wr,
  input  dt_cfg_pkg::cfg_op_e       cfg_addr,
  input  logic [31:0]               cfg_wdata,
  // Tree and tuple stream
  input  logic [63:0]               in_tdata,
  input  logic                      in_tvalid,
  input  logic                      in_tlast,
  output logic                      in_tready,
  // Result stream
  output dt_stream_pkg::dt_result_t out_tdata,
  output logic                      out_tvalid,
  output logic                      out_tlast,
  input  logic                      out_tready
);

  localparam int AW = $clog2(MAX_TREES * (2 ** (MAX_DEPTH + 1)));

  dt_cfg_pkg::dt_params_t    params;
  logic                      start;
  logic                      wr_en;
  logic [AW-1:0]             wr_addr;
  dt_stream_pkg::dt_node_t   wr_node;
  logic [AW-1:0]             rd_addr;
  dt_stream_pkg::dt_node_t   rd_node;
  dt_stream_pkg::dt_tuple_t  tuple;
  logic                      tuple_valid;
  logic                      tuple_ready;
  dt_stream_pkg::dt_result_t res;
  logic                      res_valid;
  logic                      res_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////////////////////

  dt_param_regs u_param_regs (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .params    (params),
    .start     (start)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Input stream and tree store
  ////////////////////////////////////////////////////////////////////////////

  dt_stream_reader #(
    .MAX_TREES (MAX_TREES),
    .MAX_DEPTH (MAX_DEPTH)
  ) u_stream_reader (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .start       (start),
    .params      (params),
    .in_tdata    (in_tdata),
    .in_tvalid   (in_tvalid),
    .in_tlast    (in_tlast),
    .tuple_ready (tuple_ready),
    .in_tready   (in_tready),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_node     (wr_node),
    .tuple       (tuple),
    .tuple_valid (tuple_valid)
  );

  dt_tree_memory #(
    .MAX_TREES (MAX_TREES),
    .MAX_DEPTH (MAX_DEPTH)
  ) u_tree_memory (
    .aclk    (aclk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_node (wr_node),
    .rd_addr (rd_addr),
    .rd_node (rd_node)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Inference and output
  ////////////////////////////////////////////////////////////////////////////

  dt_tree_walker #(
    .MAX_TREES (MAX_TREES),
    .MAX_DEPTH (MAX_DEPTH)
  ) u_tree_walker (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .start       (start),
    .params      (params),
    .tuple       (tuple),
    .tuple_valid (tuple_valid),
    .res_ready   (res_ready),
    .rd_node     (rd_node),
    .tuple_ready (tuple_ready),
    .rd_addr     (rd_addr),
    .res         (res),
    .res_valid   (res_valid)
  );

  dt_result_packer u_result_packer (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .params     (params),
    .res        (res),
    .res_valid  (res_valid),
    .out_tready (out_tready),
    .res_ready  (res_ready),
    .out_tdata  (out_tdata),
    .out_tvalid (out_tvalid),
    .out_tlast  (out_tlast)
  );

endmodule

// File: design/dt_param_regs.sv
module dt_param_regs (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   cfg_wr,
  input  dt_cfg_pkg::cfg_op_e    cfg_addr,
  input  logic [31:0]            cfg_wdata,
  output dt_cfg_pkg::dt_params_t params,
  output logic                   start
);

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  // Each write lands in its field one cycle after the strobe
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      params <= '0;
      start  <= 1'b0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        dt_cfg_pkg::OP_CTRL:       start             <= cfg_wdata[0];
        dt_cfg_pkg::OP_NUM_TREES:  params.num_trees  <= cfg_wdata[2:0];
        dt_cfg_pkg::OP_DEPTH:      params.depth      <= cfg_wdata[1:0];
        dt_cfg_pkg::OP_NUM_TUPLES: params.num_tuples <= cfg_wdata[15:0];
        default: ;
      endcase
    end
  end

  // Host must never load an empty forest or a flat tree
  a_no_zero_shape: assert property (
    @(posedge aclk) disable iff (!aresetn)
    cfg_wr |->
      !(cfg_addr == dt_cfg_pkg::OP_NUM_TREES && cfg_wdata[2:0] == 3'd0) &&
      !(cfg_addr == dt_cfg_pkg::OP_DEPTH && cfg_wdata[1:0] == 2'd0)
  );

endmodule

// File: design/dt_result_packer.sv
module dt_result_packer (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  dt_cfg_pkg::dt_params_t    params,
  input  dt_stream_pkg::dt_result_t res,
  input  logic                      res_valid,
  input  logic                      out_tready,
  output logic                      res_ready,
  output dt_stream_pkg::dt_result_t out_tdata,
  output logic                      out_tvalid,
  output logic                      out_tlast
);

  logic [15:0] beat_cnt;

  // Straight handshake pass-through
  assign out_tdata  = res;
  assign out_tvalid = res_valid;
  assign res_ready  = out_tready;

  // Final beat of the run
  assign out_tlast = beat_cnt == params.num_tuples - 16'd1;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_cnt <= '0;
    end else if (out_tvalid && out_tready) begin
      // Back to zero for the next run
      beat_cnt <= out_tlast ? 16'd0 : beat_cnt + 16'd1;
    end
  end

  // Walker numbering and beat count agree at the end of a run
  a_last_index: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_tvalid && out_tlast |-> out_tdata.tuple_index == params.num_tuples - 16'd1
  );

endmodule

// File: design/dt_stream_pkg.sv
package dt_stream_pkg;

  // One tree beat, feature select in the low bits
  typedef struct packed {
    logic [36:0] pad;
    logic [15:0] leaf_value;  // Unsigned, only read at leaves
    logic [7:0]  threshold;
    logic [2:0]  feature;     // Tested feature at internal nodes
  } dt_node_t;

  // Eight unsigned features, feature 0 in the low byte
  typedef logic [7:0][7:0] dt_tuple_t;

  // One result beat
  typedef struct packed {
    logic [15:0] pad;
    logic [31:0] score;       // Sum of leaf values over all trees
    logic [15:0] tuple_index;
  } dt_result_t;

  // Input stream phases
  typedef enum logic [1:0] {
    IDLE           = 2'd0,
    READ_TREES     = 2'd1,
    WAIT_ALL_TREES = 2'd2,
    READ_DATA      = 2'd3
  } reader_state_e;

endpackage

// File: design/dt_stream_reader.sv
module dt_stream_reader #(
  parameter  int MAX_TREES = 4,
  parameter  int MAX_DEPTH = 3,
  localparam int STRIDE    = 2 ** (MAX_DEPTH + 1),
  localparam int AW        = $clog2(MAX_TREES * STRIDE)
) (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     start,
  input  dt_cfg_pkg::dt_params_t   params,
  input  logic [63:0]              in_tdata,
  input  logic                     in_tvalid,
  input  logic                     in_tlast,
  input  logic                     tuple_ready,
  output logic                     in_tready,
  output logic                     wr_en,
  output logic [AW-1:0]            wr_addr,
  output dt_stream_pkg::dt_node_t  wr_node,
  output dt_stream_pkg::dt_tuple_t tuple,
  output logic                     tuple_valid
);

  localparam int TW = $clog2(MAX_TREES + 1);
  localparam int IW = MAX_DEPTH + 1;

  dt_stream_pkg::reader_state_e state;
  dt_stream_pkg::reader_state_e state_nxt;
  logic                         start_r;
  logic                         start_pulse;
  logic                         start_pulse_d1;
  logic [TW-1:0]                tree_cnt;
  logic [IW-1:0]                node_idx;
  logic [IW-1:0]                node_last;
  logic                         in_beat;

  ////////////////////////////////////////////////////////////////////////////
  // Start edge and phase machine
  ////////////////////////////////////////////////////////////////////////////

  assign start_pulse = start & ~start_r;
  assign in_beat     = in_tvalid & in_tready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      start_r        <= 1'b0;
      start_pulse_d1 <= 1'b0;
      state          <= dt_stream_pkg::IDLE;
    end else begin
      start_r        <= start;
      start_pulse_d1 <= start_pulse;
      state          <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      dt_stream_pkg::IDLE:
        if (start_pulse_d1) state_nxt = dt_stream_pkg::READ_TREES;
      dt_stream_pkg::READ_TREES:
        if (in_beat && in_tlast) state_nxt = dt_stream_pkg::WAIT_ALL_TREES;
      // Single settle cycle between phases
      dt_stream_pkg::WAIT_ALL_TREES:
        state_nxt = dt_stream_pkg::READ_DATA;
      dt_stream_pkg::READ_DATA:
        if (in_beat && in_tlast) state_nxt = dt_stream_pkg::IDLE;
      default:
        state_nxt = dt_stream_pkg::IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tree loading
  ////////////////////////////////////////////////////////////////////////////

  // Last heap index of one tree, 2^(depth+1)-1
  assign node_last = IW'((32'd2 << params.depth) - 32'd1);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      tree_cnt <= '0;
      node_idx <= IW'(1);
    end else if (start_pulse_d1) begin
      tree_cnt <= '0;
      node_idx <= IW'(1);
    end else if (wr_en) begin
      if (node_idx == node_last) begin
        node_idx <= IW'(1);
        tree_cnt <= tree_cnt + 1'b1;
      end else begin
        node_idx <= node_idx + 1'b1;
      end
    end
  end

  // Always ready while loading trees
  assign wr_en   = (state == dt_stream_pkg::READ_TREES) && in_tvalid;
  assign wr_addr = AW'(tree_cnt) * AW'(STRIDE) + AW'(node_idx);
  assign wr_node = in_tdata;

  ////////////////////////////////////////////////////////////////////////////
  // Tuple forwarding and ready
  ////////////////////////////////////////////////////////////////////////////

  assign tuple       = in_tdata;
  assign tuple_valid = (state == dt_stream_pkg::READ_DATA) && in_tvalid;

  always_comb begin
    case (state)
      dt_stream_pkg::READ_TREES: in_tready = 1'b1;
      dt_stream_pkg::READ_DATA:  in_tready = tuple_ready;
      default:                   in_tready = 1'b0;
    endcase
  end

  // Writes only land in READ_TREES and inside the configured forest
  a_wr_in_trees: assert property (
    @(posedge aclk) disable iff (!aresetn)
    wr_en |-> state == dt_stream_pkg::READ_TREES &&
              int'(tree_cnt) < int'(params.num_trees)
  );

endmodule

// File: design/dt_tree_memory.sv
module dt_tree_memory #(
  parameter  int MAX_TREES = 4,
  parameter  int MAX_DEPTH = 3,
  localparam int DEPTH     = MAX_TREES * (2 ** (MAX_DEPTH + 1)),
  localparam int AW        = $clog2(DEPTH)
) (
  input  logic                    aclk,
  input  logic                    wr_en,
  input  logic [AW-1:0]           wr_addr,
  input  dt_stream_pkg::dt_node_t wr_node,
  input  logic [AW-1:0]           rd_addr,
  output dt_stream_pkg::dt_node_t rd_node
);

  // All trees, one stride per tree, slot 0 unused
  dt_stream_pkg::dt_node_t mem [DEPTH];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_node;
    end
  end

  // Registered read, node appears one cycle after rd_addr
  always_ff @(posedge aclk) begin
    rd_node <= mem[rd_addr];
  end

endmodule

// File: design/dt_tree_walker.sv
module dt_tree_walker #(
  parameter  int MAX_TREES = 4,
  parameter  int MAX_DEPTH = 3,
  localparam int STRIDE    = 2 ** (MAX_DEPTH + 1),
  localparam int AW        = $clog2(MAX_TREES * STRIDE)
) (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       start,
  input  dt_cfg_pkg::dt_params_t     params,
  input  dt_stream_pkg::dt_tuple_t   tuple,
  input  logic                       tuple_valid,
  input  logic                       res_ready,
  input  dt_stream_pkg::dt_node_t    rd_node,
  output logic                       tuple_ready,
  output logic [AW-1:0]              rd_addr,
  output dt_stream_pkg::dt_result_t  res,
  output logic                       res_valid
);

  localparam int TW = $clog2(MAX_TREES + 1);
  localparam int IW = MAX_DEPTH + 1;
  localparam int LW = $clog2(MAX_DEPTH + 1);

  // ROOT issues the root fetch, WALK sees one node per cycle
  typedef enum logic [1:0] {
    W_IDLE,
    W_ROOT,
    W_WALK,
    W_DONE
  } walk_state_e;

  walk_state_e              state;
  logic                     start_r;
  logic                     start_pulse;
  logic [TW-1:0]            tree_cnt;
  logic [LW-1:0]            level;
  logic [IW-1:0]            node_idx;
  logic [IW-1:0]            next_idx;
  logic                     go_right;
  logic                     at_leaf;
  logic                     last_tree;
  logic [15:0]              tuple_idx;
  logic [31:0]              acc;
  dt_stream_pkg::dt_tuple_t tuple_r;

  ////////////////////////////////////////////////////////////////////////////
  // Node decision
  ////////////////////////////////////////////////////////////////////////////

  // Right child when the feature exceeds the threshold
  assign go_right  = tuple_r[rd_node.feature] > rd_node.threshold;
  assign next_idx  = {node_idx[IW-2:0], go_right};
  assign at_leaf   = int'(level) == int'(params.depth);
  assign last_tree = int'(tree_cnt) + 1 == int'(params.num_trees);

  // Root on a new tree, otherwise the chosen child
  assign rd_addr = AW'(tree_cnt) * AW'(STRIDE) +
                   AW'((state == W_WALK) ? next_idx : IW'(1));

  assign start_pulse = start & ~start_r;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= W_IDLE;
      start_r   <= 1'b0;
      tree_cnt  <= '0;
      level     <= '0;
      tuple_idx <= '0;
    end else begin
      start_r <= start;
      case (state)
        W_IDLE: begin
          if (tuple_valid) begin
            state    <= W_ROOT;
            tree_cnt <= '0;
          end
        end
        W_ROOT: begin
          state <= W_WALK;
          level <= '0;
        end
        W_WALK: begin
          if (!at_leaf) begin
            level <= level + 1'b1;
          end else if (last_tree) begin
            state <= W_DONE;
          end else begin
            state    <= W_ROOT;
            tree_cnt <= tree_cnt + 1'b1;
          end
        end
        // Hold result until the packer takes it
        W_DONE: begin
          if (res_ready) begin
            state     <= W_IDLE;
            tuple_idx <= tuple_idx + 16'd1;
          end
        end
        default: state <= W_IDLE;
      endcase
      // New run numbers tuples from zero
      if (start_pulse) begin
        tuple_idx <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tuple, heap index and accumulator
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (state == W_IDLE && tuple_valid) begin
      tuple_r <= tuple;
      acc     <= '0;
    end
    if (state == W_ROOT) begin
      node_idx <= IW'(1);
    end
    if (state == W_WALK) begin
      node_idx <= next_idx;
      if (at_leaf) begin
        acc <= acc + 32'(rd_node.leaf_value);
      end
    end
  end

  assign tuple_ready     = state == W_IDLE;
  assign res_valid       = state == W_DONE;
  assign res.pad         = '0;
  assign res.score       = acc;
  assign res.tuple_index = tuple_idx;

  // Stalled result must not move
  a_res_stable: assert property (
    @(posedge aclk) disable iff (!aresetn)
    res_valid && !res_ready |=> res_valid && $stable(res)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the decision-tree testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module dt_inference_tb \
  -Mdir obj_dir -o dt_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dt_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi

exit 0

// File: src.f
+incdir+test
design/dt_cfg_pkg.sv
design/dt_stream_pkg.sv
design/dt_param_regs.sv
design/dt_stream_reader.sv
design/dt_tree_memory.sv
design/dt_tree_walker.sv
design/dt_result_packer.sv
design/dt_inference_top.sv
test/dt_inference_tb.sv

// File: test/dt_tb_model.svh
`ifndef DT_TB_MODEL_SVH
`define DT_TB_MODEL_SVH

// Testbench-side layout, 16 slots per tree, slot 0 unused
localparam int MODEL_STRIDE     = 16;
localparam int MODEL_MAX_TUPLES = 32;

// Images for two runs
dt_stream_pkg::dt_node_t   tree_img  [2][4*MODEL_STRIDE];
dt_stream_pkg::dt_tuple_t  tuple_img [2][MODEL_MAX_TUPLES];
// Expected result beats in tuple order
dt_stream_pkg::dt_result_t exp_q [$];

// Random forest, heap order per tree
task automatic build_trees(input int run, input int ntrees, input int depth);
  dt_stream_pkg::dt_node_t node;
  for (int t = 0; t < ntrees; t++) begin
    for (int i = 1; i < (2 << depth); i++) begin
      node            = '0;
      node.feature    = 3'($random(seed));
      node.threshold  = 8'($random(seed));
      node.leaf_value = 16'($random(seed));
      tree_img[run][t*MODEL_STRIDE + i] = node;
    end
  end
endtask

task automatic build_tuples(input int run, input int ntup);
  for (int k = 0; k < ntup; k++) begin
    tuple_img[run][k] = {$random(seed), $random(seed)};
  end
endtask

// Walk rule: left when feature <= threshold, leaf after depth steps
function automatic logic [31:0] walk_score(input int run, input int ntrees,
                                           input int depth,
                                           input dt_stream_pkg::dt_tuple_t tup);
  dt_stream_pkg::dt_node_t node;
  int                      idx;
  logic [31:0]             sum;
  sum = '0;
  for (int t = 0; t < ntrees; t++) begin
    idx = 1;
    for (int lvl = 0; lvl < depth; lvl++) begin
      node = tree_img[run][t*MODEL_STRIDE + idx];
      if (tup[node.feature] <= node.threshold) begin
        idx = 2 * idx;
      end else begin
        idx = 2 * idx + 1;
      end
    end
    sum = sum + 32'(tree_img[run][t*MODEL_STRIDE + idx].leaf_value);
  end
  return sum;
endfunction

// One expected beat per tuple, index from zero
task automatic push_expected(input int run, input int ntrees, input int depth,
                             input int ntup);
  dt_stream_pkg::dt_result_t r;
  for (int k = 0; k < ntup; k++) begin
    r             = '0;
    r.score       = walk_score(run, ntrees, depth, tuple_img[run][k]);
    r.tuple_index = 16'(k);
    exp_q.push_back(r);
  end
endtask

`endif

// File: test/dt_inference_tb.sv
module dt_inference_tb;

  localparam int WAIT_LIMIT = 2000;

  logic                      aclk       = 1'b0;
  logic                      aresetn    = 1'b0;
  logic                      cfg_wr     = 1'b0;
  dt_cfg_pkg::cfg_op_e       cfg_addr   = dt_cfg_pkg::OP_CTRL;
  logic [31:0]               cfg_wdata  = '0;
  logic [63:0]               in_tdata   = '0;
  logic                      in_tvalid  = 1'b0;
  logic                      in_tlast   = 1'b0;
  logic                      in_tready;
  dt_stream_pkg::dt_result_t out_tdata;
  logic                      out_tvalid;
  logic                      out_tlast;
  logic                      out_tready = 1'b0;

  int                        seed;
  int                        errors         = 0;
  int                        timeouts       = 0;
  int                        rx_total       = 0;
  int                        exp_count      = 0;
  dt_stream_pkg::dt_result_t exp_head       = '0;
  logic [15:0]               run_tuples     = '0;
  logic                      start_written  = 1'b0;
  logic                      awaiting_tuple = 1'b1;
  logic                      stall_pat [4096];
  logic [11:0]               stall_pos      = '0;

  `include "dt_tb_model.svh"

  dt_inference_top #(
    .MAX_TREES (4),
    .MAX_DEPTH (3)
  ) dut (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .in_tdata   (in_tdata),
    .in_tvalid  (in_tvalid),
    .in_tlast   (in_tlast),
    .in_tready  (in_tready),
    .out_tdata  (out_tdata),
    .out_tvalid (out_tvalid),
    .out_tlast  (out_tlast),
    .out_tready (out_tready)
  );

  initial begin
    forever #20 aclk = ~aclk;
  end

  // Random back-pressure from a precomputed pattern
  always @(negedge aclk) begin
    out_tready <= stall_pat[stall_pos];
    stall_pos  <= stall_pos + 12'd1;
  end

  // Expected queue front advances on each output transfer
  always @(posedge aclk) begin
    if (out_tvalid && out_tready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      rx_total++;
    end
    exp_count <= exp_q.size();
    if (exp_q.size() > 0) begin
      exp_head <= exp_q[0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_quiet_before_start: assert property (
    @(posedge aclk) disable iff (!aresetn)
    !start_written |-> !in_tready && !out_tvalid
  ) else begin
    errors++;
    $display("[ERROR] in_tready=%h out_tvalid=%h before start, expected 0 0",
             $sampled(in_tready), $sampled(out_tvalid));
  end

  // Tree beats must never show up as results
  a_no_early_result: assert property (
    @(posedge aclk) disable iff (!aresetn)
    awaiting_tuple |-> !out_tvalid
  ) else begin
    errors++;
    $display("[ERROR] out_tvalid=%h before first tuple, expected 0", $sampled(out_tvalid));
  end

  a_result_expected: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_tvalid |-> exp_count != 0
  ) else begin
    errors++;
    $display("Result beat offered while no result was outstanding");
  end

  a_score: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_tvalid && out_tready |-> out_tdata.score == exp_head.score
  ) else begin
    errors++;
    $display("[ERROR] out_tdata.score got %h expected %h",
             $sampled(out_tdata.score), $sampled(exp_head.score));
  end

  a_index: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_tvalid && out_tready |-> out_tdata.tuple_index == exp_head.tuple_index
  ) else begin
    errors++;
    $display("[ERROR] out_tdata.tuple_index got %h expected %h",
             $sampled(out_tdata.tuple_index), $sampled(exp_head.tuple_index));
  end

  // Last only on beat num_tuples-1
  a_last: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_tvalid && out_tready |->
      out_tlast == (exp_head.tuple_index == run_tuples - 16'd1)
  ) else begin
    errors++;
    $display("[ERROR] out_tlast got %h expected %h at tuple_index %h",
             $sampled(out_tlast),
             $sampled(exp_head.tuple_index) == $sampled(run_tuples) - 16'd1,
             $sampled(exp_head.tuple_index));
  end

  a_hold: assert property (
    @(posedge aclk) disable iff (!aresetn)
    out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
  ) else begin
    errors++;
    $display("[ERROR] out_tdata moved under stall, out_tvalid=%h out_tdata=%h",
             $sampled(out_tvalid), $sampled(out_tdata));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Starts on a falling edge and returns on the next one
  task automatic write_reg(input dt_cfg_pkg::cfg_op_e op, input logic [31:0] data);
    cfg_wr    = 1'b1;
    cfg_addr  = op;
    cfg_wdata = data;
    @(negedge aclk);
    cfg_wr    = 1'b0;
  endtask

  // Ready seen high here means the beat transfers at the next rise
  task automatic send_beat(input logic [63:0] data, input logic last);
    int waited;
    waited    = 0;
    in_tdata  = data;
    in_tvalid = 1'b1;
    in_tlast  = last;
    while (!in_tready && waited < WAIT_LIMIT) begin
      @(negedge aclk);
      waited++;
    end
    if (!in_tready) begin
      timeouts++;
      $display("Timeout while waiting for in_tready on an input beat");
    end else begin
      @(negedge aclk);
    end
    in_tvalid = 1'b0;
    in_tlast  = 1'b0;
  endtask

  task automatic run_inference(input int run, input int ntrees, input int depth,
                               input int ntup);
    int waited;
    int last_idx;
    last_idx = (2 << depth) - 1;
    // Low first so the later write is a fresh edge
    write_reg(dt_cfg_pkg::OP_CTRL, 32'd0);
    write_reg(dt_cfg_pkg::OP_NUM_TREES, 32'(ntrees));
    write_reg(dt_cfg_pkg::OP_DEPTH, 32'(depth));
    write_reg(dt_cfg_pkg::OP_NUM_TUPLES, 32'(ntup));
    push_expected(run, ntrees, depth, ntup);
    run_tuples     = 16'(ntup);
    awaiting_tuple = 1'b1;
    start_written  = 1'b1;
    write_reg(dt_cfg_pkg::OP_CTRL, 32'd1);
    for (int t = 0; t < ntrees; t++) begin
      for (int i = 1; i <= last_idx; i++) begin
        send_beat(tree_img[run][t*MODEL_STRIDE + i], t == ntrees - 1 && i == last_idx);
        if (timeouts != 0) return;
      end
    end
    for (int k = 0; k < ntup; k++) begin
      send_beat(tuple_img[run][k], k == ntup - 1);
      if (timeouts != 0) return;
      awaiting_tuple = 1'b0;
    end
    // Drain all outstanding results
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(negedge aclk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("Timeout with %0d result beats never delivered", exp_q.size());
    end
  endtask

  initial begin
    seed = 32'h4f9b69f3;
    build_trees(0, 4, 3);
    build_tuples(0, 20);
    build_trees(1, 2, 1);
    build_tuples(1, 12);
    // Ready high about three cycles in four
    for (int k = 0; k < 4096; k++) begin
      stall_pat[k] = ($random(seed) & 3) != 0;
    end
    repeat (2) @(negedge aclk);
    aresetn = 1'b1;
    // Idle window after reset
    repeat (6) @(negedge aclk);
    run_inference(0, 4, 3, 20);
    if (timeouts == 0) begin
      run_inference(1, 2, 1, 12);
    end
    repeat (4) @(negedge aclk);
    $display("Checked %0d result beats, %0d errors, %0d timeouts",
             rx_total, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
